/* files.f */
hw/tinker_isa_pkg.sv
hw/tinker_word_pkg.sv
hw/tinker_alu.sv
hw/tinker_branch_unit.sv
hw/tinker_regfile.sv
hw/tinker_memory.sv
hw/tinker_core.sv
verif/tinker_core_sva.sv
verif/tinker_core_tb.sv

/* hw/tinker_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module tinker_alu (
    input  tinker_isa_pkg::opcode_e op,
    input  tinker_word_pkg::word_t  pc,
    input  tinker_word_pkg::word_t  a,
    input  tinker_word_pkg::word_t  b,
    input  tinker_word_pkg::word_t  d,
    output tinker_word_pkg::word_t  result,
    output tinker_word_pkg::word_t  mem_wdata,
    output tinker_word_pkg::addr_t  mem_addr,
    output logic                    reg_we,
    output logic                    mem_we
);
    import tinker_isa_pkg::*;
    import tinker_word_pkg::*;

    // effective address before truncation to the memory width
    word_t eff_addr;

    // load is based on rs, store on rd
    always_comb begin
        if (op == op_store) begin
            eff_addr = d + b;
        end else begin
            eff_addr = a + b;
        end
    end

    assign mem_addr = eff_addr[addr_w-1:0];

    // store data always comes from rs
    assign mem_wdata = a;

    always_comb begin
        // sequential pc for ops that write nothing, never committed
        result = pc + word_t'(inst_bytes);
        reg_we = 1'b0;
        mem_we = 1'b0;
        case (op)
            op_add:    begin result = a + b;  reg_we = 1'b1; end
            op_sub:    begin result = a - b;  reg_we = 1'b1; end
            // immediate forms work on rd in place
            op_addi:   begin result = d + b;  reg_we = 1'b1; end
            op_subi:   begin result = d - b;  reg_we = 1'b1; end
            op_and:    begin result = a & b;  reg_we = 1'b1; end
            op_or:     begin result = a | b;  reg_we = 1'b1; end
            op_xor:    begin result = a ^ b;  reg_we = 1'b1; end
            op_not:    begin result = ~a;     reg_we = 1'b1; end
            // logical shifts
            op_shftr:  begin result = a >> b; reg_we = 1'b1; end
            op_shftl:  begin result = a << b; reg_we = 1'b1; end
            op_shftri: begin result = d >> b; reg_we = 1'b1; end
            op_shftli: begin result = d << b; reg_we = 1'b1; end
            op_mov:    begin result = a;      reg_we = 1'b1; end
            op_mov_l: begin
                // only the low literal bits of rd change
                result = {d[word_w-1:lit_w], b[lit_w-1:0]};
                reg_we = 1'b1;
            end
            op_load: begin
                // address here, memory data is swapped in at MEM
                result = eff_addr;
                reg_we = 1'b1;
            end
            op_store: begin
                mem_we = 1'b1;
            end
            default: begin
                // branches, halt and unknown codes write nothing
                reg_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/tinker_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tinker_branch_unit (
    input  tinker_isa_pkg::opcode_e op,
    input  tinker_word_pkg::word_t  pc,
    input  tinker_word_pkg::word_t  a,
    input  tinker_word_pkg::word_t  b,
    input  tinker_word_pkg::word_t  d,
    output logic                    taken,
    output tinker_word_pkg::word_t  target
);
    import tinker_isa_pkg::*;

    always_comb begin
        taken  = 1'b0;
        target = d;
        case (op)
            // absolute jump to rd
            op_br: begin
                taken  = 1'b1;
                target = d;
            end
            // relative by rd
            op_brr: begin
                taken  = 1'b1;
                target = pc + d;
            end
            // relative by sign-extended literal
            op_brr_l: begin
                taken  = 1'b1;
                target = pc + b;
            end
            // conditional on rs, target in rd
            op_brnz: begin
                taken  = (a != '0);
                target = d;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/tinker_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tinker_core #(
    parameter int                     mem_bytes = 65536,
    parameter tinker_word_pkg::word_t reset_pc  = 64'h2000,
    parameter tinker_word_pkg::word_t sp_reset  = tinker_word_pkg::word_t'(mem_bytes)
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      prog_we,
    input  tinker_word_pkg::addr_t    prog_addr,
    input  tinker_isa_pkg::inst_t     prog_data,
    output logic                      hlt,
    output logic                      wb_valid,
    output tinker_word_pkg::reg_idx_t wb_rd,
    output tinker_word_pkg::word_t    wb_data,
    output logic                      st_valid,
    output tinker_word_pkg::addr_t    st_addr,
    output tinker_word_pkg::word_t    st_data
);
    import tinker_isa_pkg::*;
    import tinker_word_pkg::*;

    // fetch
    word_t    pc;
    inst_t    inst;

    // IF/ID
    logic     if_id_valid;
    inst_t    if_id_inst;
    word_t    if_id_pc;

    // decode
    opcode_e  if_op;
    reg_idx_t if_rd;
    reg_idx_t if_rs;
    reg_idx_t if_rt;
    literal_t if_lit;
    logic     if_uses_rt;
    word_t    rf_rs;
    word_t    rf_rt;
    word_t    rf_rd;
    word_t    dec_a;
    word_t    dec_b;
    word_t    dec_d;

    // ID/EX
    logic     id_ex_valid;
    opcode_e  id_ex_op;
    word_t    id_ex_pc;
    reg_idx_t id_ex_rd;
    reg_idx_t id_ex_rs;
    reg_idx_t id_ex_rt;
    logic     id_ex_uses_rt;
    word_t    id_ex_a;
    word_t    id_ex_b;
    word_t    id_ex_d;

    // execute
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_d;
    word_t    alu_result;
    word_t    alu_wdata;
    addr_t    alu_addr;
    logic     alu_reg_we;
    logic     alu_mem_we;
    logic     br_taken;
    word_t    br_target;

    // EX/MEM
    logic     ex_mem_valid;
    opcode_e  ex_mem_op;
    reg_idx_t ex_mem_rd;
    logic     ex_mem_reg_we;
    logic     ex_mem_mem_we;
    logic     ex_mem_taken;
    word_t    ex_mem_result;
    word_t    ex_mem_wdata;
    word_t    ex_mem_target;
    addr_t    ex_mem_addr;
    word_t    mem_rdata;

    // MEM/WB
    logic     mem_wb_valid;
    opcode_e  mem_wb_op;
    reg_idx_t mem_wb_rd;
    logic     mem_wb_reg_we;
    word_t    mem_wb_data;

    // hazard control
    logic     redirect;
    logic     load_use;
    logic     halt_pending;

    // the writeback being retired this cycle
    function automatic word_t wb_bypass(reg_idx_t idx, word_t rf_val);
        if (wb_valid && wb_rd == idx) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    // youngest producer first
    function automatic word_t fwd(reg_idx_t idx, word_t id_val);
        if (ex_mem_valid && ex_mem_reg_we && ex_mem_rd == idx) begin
            return ex_mem_result;
        end
        return wb_bypass(idx, id_val);
    endfunction

    tinker_memory #(
        .mem_bytes (mem_bytes)
    ) u_memory (
        .clk        (clk),
        .fetch_addr (pc[addr_w-1:0]),
        .data_addr  (ex_mem_addr),
        .prog_addr  (prog_addr),
        .we         (st_valid),
        .prog_we    (prog_we),
        .wdata      (ex_mem_wdata),
        .prog_data  (prog_data),
        .inst       (inst),
        .rdata      (mem_rdata)
    );

    // field split of the IF/ID word
    assign if_op  = opcode_e'(if_id_inst[op_msb:op_lsb]);
    assign if_rd  = if_id_inst[rd_msb:rd_lsb];
    assign if_rs  = if_id_inst[rs_msb:rs_lsb];
    assign if_rt  = if_id_inst[rt_msb:rt_lsb];
    assign if_lit = if_id_inst[lit_msb:lit_lsb];

    // three-register forms read rt, all others take the literal
    assign if_uses_rt = (if_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                       op_shftr, op_shftl});

    tinker_regfile #(
        .sp_reset (sp_reset)
    ) u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (wb_valid),
        .wa     (wb_rd),
        .ra_s   (if_rs),
        .ra_t   (if_rt),
        .ra_d   (if_rd),
        .wd     (wb_data),
        .rs_val (rf_rs),
        .rt_val (rf_rt),
        .rd_val (rf_rd)
    );

    // decode operands, MEM/WB covers the write the regfile has not taken yet
    always_comb begin
        dec_a = wb_bypass(if_rs, rf_rs);
        dec_d = wb_bypass(if_rd, rf_rd);
        if (if_uses_rt) begin
            dec_b = wb_bypass(if_rt, rf_rt);
        end else begin
            dec_b = word_t'($signed(if_lit));
        end
    end

    // execute operands after forwarding
    always_comb begin
        ex_a = fwd(id_ex_rs, id_ex_a);
        ex_d = fwd(id_ex_rd, id_ex_d);
        if (id_ex_uses_rt) begin
            ex_b = fwd(id_ex_rt, id_ex_b);
        end else begin
            ex_b = id_ex_b;
        end
    end

    tinker_alu u_alu (
        .op        (id_ex_op),
        .pc        (id_ex_pc),
        .a         (ex_a),
        .b         (ex_b),
        .d         (ex_d),
        .result    (alu_result),
        .mem_wdata (alu_wdata),
        .mem_addr  (alu_addr),
        .reg_we    (alu_reg_we),
        .mem_we    (alu_mem_we)
    );

    tinker_branch_unit u_branch (
        .op     (id_ex_op),
        .pc     (id_ex_pc),
        .a      (ex_a),
        .b      (ex_b),
        .d      (ex_d),
        .taken  (br_taken),
        .target (br_target)
    );

    // taken branch sitting in EX/MEM
    assign redirect = ex_mem_valid && ex_mem_taken;

    // load result not ready for the next instruction, conservative on rs and rd
    assign load_use = if_id_valid && id_ex_valid && (id_ex_op == op_load) &&
                      ((id_ex_rd == if_rs) || (id_ex_rd == if_rd) ||
                       (if_uses_rt && (id_ex_rd == if_rt)));

    // nothing younger than a halt may enter the pipe
    assign halt_pending = hlt ||
                          (if_id_valid && if_op == op_halt) ||
                          (id_ex_valid && id_ex_op == op_halt) ||
                          (ex_mem_valid && ex_mem_op == op_halt) ||
                          (mem_wb_valid && mem_wb_op == op_halt);

    // pc, valid bits and halt flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc           <= reset_pc;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
            hlt          <= 1'b0;
        end else begin
            mem_wb_valid <= ex_mem_valid;
            // the ID/EX instruction is younger than the branch, kill it too
            ex_mem_valid <= id_ex_valid && !redirect;
            if (mem_wb_valid && mem_wb_op == op_halt) begin
                hlt <= 1'b1;
            end
            if (redirect) begin
                pc          <= ex_mem_target;
                if_id_valid <= 1'b0;
                id_ex_valid <= 1'b0;
            end else if (load_use) begin
                // hold pc and IF/ID, bubble into ID/EX
                id_ex_valid <= 1'b0;
            end else begin
                id_ex_valid <= if_id_valid;
                if_id_valid <= !halt_pending;
                if (!halt_pending) begin
                    pc <= pc + word_t'(inst_bytes);
                end
            end
        end
    end

    // stage payloads, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (!load_use) begin
            if_id_inst <= inst;
            if_id_pc   <= pc;
        end
        id_ex_op      <= if_op;
        id_ex_pc      <= if_id_pc;
        id_ex_rd      <= if_rd;
        id_ex_rs      <= if_rs;
        id_ex_rt      <= if_rt;
        id_ex_uses_rt <= if_uses_rt;
        id_ex_a       <= dec_a;
        id_ex_b       <= dec_b;
        id_ex_d       <= dec_d;
        ex_mem_op     <= id_ex_op;
        ex_mem_rd     <= id_ex_rd;
        ex_mem_reg_we <= alu_reg_we;
        ex_mem_mem_we <= alu_mem_we;
        ex_mem_taken  <= br_taken;
        ex_mem_result <= alu_result;
        ex_mem_wdata  <= alu_wdata;
        ex_mem_target <= br_target;
        ex_mem_addr   <= alu_addr;
        mem_wb_op     <= ex_mem_op;
        mem_wb_rd     <= ex_mem_rd;
        mem_wb_reg_we <= ex_mem_reg_we;
        // loads take the memory word, everything else the ALU result
        if (ex_mem_op == op_load) begin
            mem_wb_data <= mem_rdata;
        end else begin
            mem_wb_data <= ex_mem_result;
        end
    end

    // retirement and store observation
    assign wb_valid = mem_wb_valid && mem_wb_reg_we;
    assign wb_rd    = mem_wb_rd;
    assign wb_data  = mem_wb_data;

    assign st_valid = ex_mem_valid && ex_mem_mem_we;
    assign st_addr  = ex_mem_addr;
    assign st_data  = ex_mem_wdata;

endmodule

`default_nettype wire

/* hw/tinker_isa_pkg.sv */
`default_nettype none

package tinker_isa_pkg;

    // instruction word geometry
    localparam int inst_w     = 32;
    localparam int inst_bytes = inst_w / 8;
    localparam int op_w       = 5;
    localparam int lit_w      = 12;

    // field positions inside an instruction
    localparam int op_msb  = 31;
    localparam int op_lsb  = 27;
    localparam int rd_msb  = 26;
    localparam int rd_lsb  = 22;
    localparam int rs_msb  = 21;
    localparam int rs_lsb  = 17;
    localparam int rt_msb  = 16;
    localparam int rt_lsb  = 12;
    localparam int lit_msb = 11;
    localparam int lit_lsb = 0;

    typedef logic [inst_w-1:0] inst_t;

    // sign-extended wherever it feeds an operand
    typedef logic [lit_w-1:0] literal_t;

    typedef enum logic [op_w-1:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,
        op_brr    = 5'h09,
        op_brr_l  = 5'h0a,
        op_brnz   = 5'h0b,
        op_halt   = 5'h0f,
        op_load   = 5'h10,
        op_mov    = 5'h11,
        op_mov_l  = 5'h12,
        op_store  = 5'h13,
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_e;

endpackage

`default_nettype wire

/* hw/tinker_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tinker_memory #(
    parameter int mem_bytes = 65536
) (
    input  logic                   clk,
    input  tinker_word_pkg::addr_t fetch_addr,
    input  tinker_word_pkg::addr_t data_addr,
    input  tinker_word_pkg::addr_t prog_addr,
    input  logic                   we,
    input  logic                   prog_we,
    input  tinker_word_pkg::word_t wdata,
    input  tinker_isa_pkg::inst_t  prog_data,
    output tinker_isa_pkg::inst_t  inst,
    output tinker_word_pkg::word_t rdata
);
    import tinker_isa_pkg::*;
    import tinker_word_pkg::*;

    // flat byte array, little-endian
    logic [7:0] mem [mem_bytes];

    // instruction fetch, lowest byte at the lowest address
    always_comb begin
        for (int i = 0; i < inst_bytes; i++) begin
            inst[8*i +: 8] = mem[fetch_addr + addr_t'(i)];
        end
    end

    // doubleword load
    always_comb begin
        for (int i = 0; i < word_bytes; i++) begin
            rdata[8*i +: 8] = mem[data_addr + addr_t'(i)];
        end
    end

    always_ff @(posedge clk) begin
        // program loading wins over a data store
        if (prog_we) begin
            for (int i = 0; i < inst_bytes; i++) begin
                mem[prog_addr + addr_t'(i)] <= prog_data[8*i +: 8];
            end
        end else if (we) begin
            for (int i = 0; i < word_bytes; i++) begin
                mem[data_addr + addr_t'(i)] <= wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/tinker_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tinker_regfile #(
    parameter tinker_word_pkg::word_t sp_reset = 64'h10000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      we,
    input  tinker_word_pkg::reg_idx_t wa,
    input  tinker_word_pkg::reg_idx_t ra_s,
    input  tinker_word_pkg::reg_idx_t ra_t,
    input  tinker_word_pkg::reg_idx_t ra_d,
    input  tinker_word_pkg::word_t    wd,
    output tinker_word_pkg::word_t    rs_val,
    output tinker_word_pkg::word_t    rt_val,
    output tinker_word_pkg::word_t    rd_val
);
    import tinker_word_pkg::*;

    word_t regs [reg_count];

    // r0 is an ordinary register in this ISA
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                // stack pointer starts at the top of memory
                if (i == sp_reg) begin
                    regs[i] <= sp_reset;
                end else begin
                    regs[i] <= '0;
                end
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // three async read ports
    // a write in the same cycle is not visible here yet
    assign rs_val = regs[ra_s];
    assign rt_val = regs[ra_t];
    assign rd_val = regs[ra_d];

endmodule

`default_nettype wire

/* hw/tinker_word_pkg.sv */
`default_nettype none

package tinker_word_pkg;

    // data word
    localparam int word_w     = 64;
    localparam int word_bytes = word_w / 8;

    // byte address as seen by the memory
    localparam int addr_w = 32;

    // register file geometry
    localparam int reg_idx_w = 5;
    localparam int reg_count = 1 << reg_idx_w;

    // stack pointer lives in the last register
    localparam int sp_reg = reg_count - 1;

    typedef logic [word_w-1:0] word_t;

    typedef logic [addr_w-1:0] addr_t;

    typedef logic [reg_idx_w-1:0] reg_idx_t;

endpackage

`default_nettype wire

/* verif/tinker_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tinker_core_sva (
    input logic                      clk,
    input logic                      reset,
    input logic                      hlt,
    input logic                      wb_valid,
    input tinker_word_pkg::reg_idx_t wb_rd,
    input tinker_word_pkg::word_t    wb_data,
    input logic                      st_valid,
    input tinker_word_pkg::addr_t    st_addr,
    input tinker_word_pkg::word_t    st_data
);
    import tinker_word_pkg::*;

    // queue heads refreshed on the falling edge
    logic     wb_exp_ok;
    reg_idx_t wb_exp_rd;
    word_t    wb_exp_data;
    logic     st_exp_ok;
    addr_t    st_exp_addr;
    word_t    st_exp_data;

    // set by the first retired register write
    logic     wb_seen;

    // count of failed checks
    int err_count = 0;

    always @(negedge clk) begin
        wb_exp_ok <= (tinker_core_tb.exp_wb_rd.size() != 0);
        if (tinker_core_tb.exp_wb_rd.size() != 0) begin
            wb_exp_rd   <= tinker_core_tb.exp_wb_rd[0];
            wb_exp_data <= tinker_core_tb.exp_wb_data[0];
        end
        st_exp_ok <= (tinker_core_tb.exp_st_addr.size() != 0);
        if (tinker_core_tb.exp_st_addr.size() != 0) begin
            st_exp_addr <= tinker_core_tb.exp_st_addr[0];
            st_exp_data <= tinker_core_tb.exp_st_data[0];
        end
    end

    // consume one entry per observed event
    always @(posedge clk) begin
        if (!reset && wb_valid && tinker_core_tb.exp_wb_rd.size() != 0) begin
            void'(tinker_core_tb.exp_wb_rd.pop_front());
            void'(tinker_core_tb.exp_wb_data.pop_front());
        end
        if (!reset && st_valid && tinker_core_tb.exp_st_addr.size() != 0) begin
            void'(tinker_core_tb.exp_st_addr.pop_front());
            void'(tinker_core_tb.exp_st_data.pop_front());
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_seen <= 1'b0;
        end else if (wb_valid) begin
            wb_seen <= 1'b1;
        end
    end

    // quiet from release up to the first writeback
    a_reset_quiet: assert property (@(posedge clk) disable iff (reset)
        !wb_seen |-> !hlt && !st_valid)
        else begin
            err_count++;
            $error("hlt or st_valid active before the first writeback");
        end

    a_wb_expected: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_exp_ok)
        else begin
            err_count++;
            $error("writeback seen with no expected writeback left");
        end

    a_wb_match: assert property (@(posedge clk) disable iff (reset)
        wb_valid && wb_exp_ok |-> wb_rd == wb_exp_rd && wb_data == wb_exp_data)
        else begin
            err_count++;
            $error("Mismatch at %0t: writeback r%0d = %h, expected r%0d = %h",
                   $time, $sampled(wb_rd), $sampled(wb_data),
                   $sampled(wb_exp_rd), $sampled(wb_exp_data));
        end

    a_st_expected: assert property (@(posedge clk) disable iff (reset)
        st_valid |-> st_exp_ok)
        else begin
            err_count++;
            $error("store seen with no expected store left");
        end

    a_st_match: assert property (@(posedge clk) disable iff (reset)
        st_valid && st_exp_ok |-> st_addr == st_exp_addr && st_data == st_exp_data)
        else begin
            err_count++;
            $error("Mismatch at %0t: store [%h] = %h, expected [%h] = %h",
                   $time, $sampled(st_addr), $sampled(st_data),
                   $sampled(st_exp_addr), $sampled(st_exp_data));
        end

    // halt is sticky until reset
    a_hlt_sticky: assert property (@(posedge clk) disable iff (reset)
        hlt |=> hlt)
        else begin
            err_count++;
            $error("hlt dropped without a reset");
        end

    a_hlt_quiet: assert property (@(posedge clk) disable iff (reset)
        hlt |-> !wb_valid && !st_valid)
        else begin
            err_count++;
            $error("writeback or store after hlt");
        end

endmodule

`default_nettype wire

/* verif/tinker_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tinker_core_tb;
    import tinker_isa_pkg::*;
    import tinker_word_pkg::*;

    localparam int    mem_bytes = 65536;
    localparam word_t reset_pc  = 64'h2000;

    logic     clk;
    logic     reset;
    logic     prog_we;
    addr_t    prog_addr;
    inst_t    prog_data;
    logic     hlt;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     st_valid;
    addr_t    st_addr;
    word_t    st_data;

    // program image, slot i sits at reset_pc + 4*i
    inst_t    prog [$];

    // expected events in program order, drained by the checker
    reg_idx_t exp_wb_rd [$];
    word_t    exp_wb_data [$];
    addr_t    exp_st_addr [$];
    word_t    exp_st_data [$];

    integer   seed;
    int       executed;
    int       limit;
    int       cycles;
    int       settle;
    logic     model_bad;

    tinker_core #(
        .mem_bytes (mem_bytes),
        .reset_pc  (reset_pc)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .hlt       (hlt),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    bind tinker_core tinker_core_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic inst_t encode(opcode_e op, int rd, int rs, int rt, int lit);
        inst_t w;
        w = '0;
        w[op_msb:op_lsb]   = op;
        w[rd_msb:rd_lsb]   = rd[4:0];
        w[rs_msb:rs_lsb]   = rs[4:0];
        w[rt_msb:rt_lsb]   = rt[4:0];
        w[lit_msb:lit_lsb] = lit[11:0];
        return w;
    endfunction

    task automatic emit(opcode_e op, int rd, int rs, int rt, int lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
    endtask

    function automatic int rand_lit(int mask);
        return $random(seed) & mask;
    endfunction

    task automatic build_program();
        // dependent chain, each op feeds the next through forwarding
        emit(op_mov_l, 1, 0, 0, rand_lit(12'hfff));
        emit(op_addi, 1, 0, 0, rand_lit(12'hfff));
        emit(op_add, 2, 1, 1, 0);
        emit(op_sub, 3, 2, 1, 0);
        emit(op_subi, 3, 0, 0, rand_lit(12'hfff));
        emit(op_and, 4, 3, 2, 0);
        emit(op_or, 5, 4, 3, 0);
        emit(op_xor, 6, 5, 1, 0);
        emit(op_not, 7, 6, 0, 0);
        emit(op_mov, 8, 7, 0, 0);
        emit(op_shftli, 8, 0, 0, rand_lit(63));
        emit(op_shftri, 8, 0, 0, rand_lit(63));
        emit(op_mov_l, 9, 0, 0, rand_lit(63));
        emit(op_shftl, 10, 8, 9, 0);
        emit(op_shftr, 11, 10, 9, 0);
        emit(op_add, 12, 11, 31, 0);
        // store, then load back with a stall on rs, rd and rt
        emit(op_mov_l, 13, 0, 0, 12'hff8);
        emit(op_store, 13, 12, 0, 16);
        emit(op_load, 14, 13, 0, 16);
        emit(op_add, 15, 14, 6, 0);
        emit(op_load, 16, 13, 0, 16);
        emit(op_addi, 16, 0, 0, 5);
        emit(op_load, 17, 13, 0, 16);
        emit(op_and, 18, 6, 17, 0);
        // r20 holds reset_pc as the base for absolute targets
        emit(op_mov_l, 20, 0, 0, 1);
        emit(op_shftli, 20, 0, 0, 13);
        emit(op_mov_l, 22, 0, 0, 0);
        // brnz on zero falls through
        emit(op_mov, 21, 20, 0, 0);
        emit(op_addi, 21, 0, 0, 4 * (prog.size() + 3));
        emit(op_brnz, 21, 22, 0, 0);
        emit(op_addi, 23, 0, 0, 1);
        emit(op_addi, 23, 0, 0, 2);
        // brnz on non-zero skips two
        emit(op_mov, 21, 20, 0, 0);
        emit(op_addi, 21, 0, 0, 4 * (prog.size() + 4));
        emit(op_brnz, 21, 23, 0, 0);
        emit(op_addi, 24, 0, 0, 7);
        emit(op_addi, 24, 0, 0, 9);
        emit(op_addi, 25, 0, 0, 3);
        // absolute jump
        emit(op_mov, 21, 20, 0, 0);
        emit(op_addi, 21, 0, 0, 4 * (prog.size() + 4));
        emit(op_br, 21, 0, 0, 0);
        emit(op_addi, 24, 0, 0, 1);
        emit(op_addi, 24, 0, 0, 1);
        emit(op_addi, 26, 0, 0, 4);
        // relative by rd, then by literal
        emit(op_mov_l, 27, 0, 0, 12);
        emit(op_brr, 27, 0, 0, 0);
        emit(op_addi, 24, 0, 0, 1);
        emit(op_addi, 24, 0, 0, 1);
        emit(op_addi, 28, 0, 0, 5);
        emit(op_brr_l, 0, 0, 0, 12);
        emit(op_addi, 24, 0, 0, 1);
        emit(op_addi, 24, 0, 0, 1);
        emit(op_addi, 29, 0, 0, 6);
        emit(op_store, 13, 18, 0, 24);
        emit(op_halt, 0, 0, 0, 0);
        // never reached
        emit(op_addi, 30, 0, 0, 1);
        emit(op_store, 13, 30, 0, 32);
    endtask

    // in-order interpreter of the ISA rules
    task automatic run_model();
        word_t   regs [32];
        word_t   data_mem [addr_t];
        word_t   pc_m;
        word_t   next_pc;
        word_t   a;
        word_t   t;
        word_t   d;
        word_t   lit;
        word_t   res;
        inst_t   w;
        opcode_e op;
        addr_t   ea;
        logic    we;
        logic    halted;
        int      idx;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        regs[31] = word_t'(mem_bytes);
        pc_m = reset_pc;
        halted = 1'b0;
        executed = 0;
        while (!halted && !model_bad) begin
            idx = int'((pc_m - reset_pc) >> 2);
            if (pc_m < reset_pc || idx >= prog.size() || executed > 1000) begin
                model_bad = 1'b1;
            end else begin
                w   = prog[idx];
                op  = opcode_e'(w[op_msb:op_lsb]);
                a   = regs[w[rs_msb:rs_lsb]];
                t   = regs[w[rt_msb:rt_lsb]];
                d   = regs[w[rd_msb:rd_lsb]];
                lit = word_t'($signed(w[lit_msb:lit_lsb]));
                next_pc = pc_m + 4;
                we  = 1'b1;
                res = '0;
                case (op)
                    op_add:    res = a + t;
                    op_sub:    res = a - t;
                    op_addi:   res = d + lit;
                    op_subi:   res = d - lit;
                    op_and:    res = a & t;
                    op_or:     res = a | t;
                    op_xor:    res = a ^ t;
                    op_not:    res = ~a;
                    op_shftr:  res = a >> t;
                    op_shftl:  res = a << t;
                    op_shftri: res = d >> lit;
                    op_shftli: res = d << lit;
                    op_mov:    res = a;
                    op_mov_l:  res = {d[63:12], w[11:0]};
                    op_load: begin
                        ea = addr_t'(a + lit);
                        if (data_mem.exists(ea)) begin
                            res = data_mem[ea];
                        end else begin
                            model_bad = 1'b1;
                        end
                    end
                    op_store: begin
                        we = 1'b0;
                        ea = addr_t'(d + lit);
                        data_mem[ea] = a;
                        exp_st_addr.push_back(ea);
                        exp_st_data.push_back(a);
                    end
                    op_br: begin
                        we = 1'b0;
                        next_pc = d;
                    end
                    op_brr: begin
                        we = 1'b0;
                        next_pc = pc_m + d;
                    end
                    op_brr_l: begin
                        we = 1'b0;
                        next_pc = pc_m + lit;
                    end
                    op_brnz: begin
                        we = 1'b0;
                        if (a != '0) begin
                            next_pc = d;
                        end
                    end
                    op_halt: begin
                        we = 1'b0;
                        halted = 1'b1;
                    end
                    default: begin
                        we = 1'b0;
                        model_bad = 1'b1;
                    end
                endcase
                if (we) begin
                    regs[w[rd_msb:rd_lsb]] = res;
                    exp_wb_rd.push_back(reg_idx_t'(w[rd_msb:rd_lsb]));
                    exp_wb_data.push_back(res);
                end
                pc_m = next_pc;
                executed++;
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        model_bad = 1'b0;
        seed      = 32'h39cf;
        build_program();
        run_model();
        limit = 4 * executed + 50;
        // one word per falling edge while the core is held
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = addr_t'(reset_pc) + addr_t'(4 * i);
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (!hlt && dut.u_sva.err_count == 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        // let the halted core idle to see it stays quiet
        settle = 0;
        while (hlt && dut.u_sva.err_count == 0 && settle < 8) begin
            @(negedge clk);
            settle++;
        end
        if (!model_bad && dut.u_sva.err_count == 0 && hlt &&
            exp_wb_rd.size() == 0 && exp_st_addr.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            if (model_bad) begin
                $display("reference model left the program or read unwritten data");
            end else if (dut.u_sva.err_count == 0 && !hlt) begin
                $display("timeout, hlt not seen after %0d cycles", cycles);
            end else if (dut.u_sva.err_count == 0) begin
                $display("%0d writebacks and %0d stores were never seen",
                         exp_wb_rd.size(), exp_st_addr.size());
            end
            $display("RESULT: FAIL");
            $fatal(1, "run stopped");
        end
    end

endmodule

`default_nettype wire
